//--- logic/kbd_vga_pkg.sv
package kbd_vga_pkg;

	// Make/break tracking states
	typedef enum logic [1:0] {
		st_idle,
		st_make_seen,
		st_break_pending
	} key_state_t;

	// Release prefix sent before the code of the key let go
	localparam logic [7:0] BREAK_CODE = 8'hf0;

	// 640x480 at 60 Hz, counted in pixel clocks
	localparam logic [9:0] H_VISIBLE = 10'd640;
	localparam logic [9:0] H_FRONT = 10'd16;
	localparam logic [9:0] H_SYNC = 10'd96;
	localparam logic [9:0] H_BACK = 10'd48;

	// Counted in lines
	localparam logic [9:0] V_VISIBLE = 10'd480;
	localparam logic [9:0] V_FRONT = 10'd10;
	localparam logic [9:0] V_SYNC = 10'd2;
	localparam logic [9:0] V_BACK = 10'd33;

	// Receive queue depth in bytes
	localparam int FIFO_DEPTH = 8;

endpackage

//--- logic/ps2_rx_if.sv
interface ps2_rx_if;

	logic [7:0] code;
	logic ready;
	logic overflow;
	logic pop;

	// Receiver side holds the queue
	modport source (
		output code,
		output ready,
		output overflow,
		input pop
	);

	modport sink (
		input code,
		input ready,
		input overflow,
		output pop
	);

endinterface

//--- logic/ps2_receiver.sv
module ps2_receiver #(
	parameter int FIFO_DEPTH = kbd_vga_pkg::FIFO_DEPTH
) (
	input logic clk,
	input logic rst,
	input logic ps2_clk,
	input logic ps2_data,
	output logic parity_error,
	ps2_rx_if.source rx
);
	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	logic [1:0] clk_sync;
	logic [1:0] data_sync;
	logic clk_prev;
	logic clk_fall;
	logic [3:0] bit_cnt;
	logic [10:0] frame;
	logic frame_done;
	logic frame_valid;
	logic frame_ok;
	logic [7:0] frame_byte;
	logic [7:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] fill;
	logic fifo_full;
	logic push;
	logic take;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// Idle PS/2 lines sit high
	always_ff @(posedge clk) begin
		if (rst) begin
			clk_sync <= 2'b11;
			data_sync <= 2'b11;
			clk_prev <= 1'b1;
		end else begin
			clk_sync <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
			clk_prev <= clk_sync[1];
		end
	end

	assign clk_fall = clk_prev & ~clk_sync[1];

	// Start, 8 data bits LSB first, parity, stop
	always_ff @(posedge clk) begin
		if (rst) begin
			bit_cnt <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (clk_fall) begin
				if (bit_cnt == 4'd10) begin
					bit_cnt <= '0;
					frame_done <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (clk_fall) begin
			frame <= {data_sync[1], frame[10:1]};
		end
	end

	// Odd parity over data and parity bit
	assign frame_valid = !frame[0] && frame[10] && (^frame[9:1]);

	always_ff @(posedge clk) begin
		if (rst) begin
			frame_ok <= 1'b0;
			parity_error <= 1'b0;
		end else begin
			frame_ok <= frame_done && frame_valid;
			if (frame_done && !frame_valid) begin
				parity_error <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (frame_done) begin
			frame_byte <= frame[8:1];
		end
	end

	assign fifo_full = (fill == CNT_W'(FIFO_DEPTH));
	assign push = frame_ok && !fifo_full;
	assign take = rx.pop && rx.ready;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= frame_byte;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
			rx.overflow <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (take) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			// Byte into a full queue is lost
			if (frame_ok && fifo_full) begin
				rx.overflow <= 1'b1;
			end
			case ({push, take})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	assign rx.ready = (fill != '0);
	assign rx.code = mem[rd_ptr];

	pop_needs_ready: assert property (@(posedge clk) disable iff (rst) rx.pop |-> rx.ready);
	fill_bounded: assert property (@(posedge clk) disable iff (rst)
		fill <= CNT_W'(FIFO_DEPTH));

endmodule

//--- logic/key_tracker.sv
module key_tracker (
	input logic clk,
	input logic rst,
	ps2_rx_if.sink rx,
	output logic [7:0] last_key,
	output logic key_held,
	output logic break_pending,
	output logic [7:0] press_count
);
	import kbd_vga_pkg::*;

	key_state_t state;
	key_state_t state_next;
	logic [7:0] key_next;
	logic held_next;
	logic [7:0] count_next;
	logic pop_next;

	always_comb begin
		state_next = state;
		key_next = last_key;
		held_next = key_held;
		count_next = press_count;
		pop_next = 1'b0;
		// The byte under a pop is still shown, so skip that cycle
		if (rx.ready && !rx.pop) begin
			pop_next = 1'b1;
			if (state == st_break_pending) begin
				state_next = st_idle;
				held_next = 1'b0;
				count_next = press_count + 8'd1;
			end else if (rx.code == BREAK_CODE) begin
				state_next = st_break_pending;
			end else begin
				state_next = st_make_seen;
				key_next = rx.code;
				held_next = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			last_key <= '0;
			key_held <= 1'b0;
			press_count <= '0;
			rx.pop <= 1'b0;
		end else begin
			state <= state_next;
			last_key <= key_next;
			key_held <= held_next;
			press_count <= count_next;
			rx.pop <= pop_next;
		end
	end

	assign break_pending = (state == st_break_pending);

	pop_single: assert property (@(posedge clk) disable iff (rst) rx.pop |=> !rx.pop);

endmodule

//--- logic/vga_timing.sv
module vga_timing #(
	parameter logic [9:0] H_VISIBLE = kbd_vga_pkg::H_VISIBLE,
	parameter logic [9:0] H_FRONT = kbd_vga_pkg::H_FRONT,
	parameter logic [9:0] H_SYNC = kbd_vga_pkg::H_SYNC,
	parameter logic [9:0] H_BACK = kbd_vga_pkg::H_BACK,
	parameter logic [9:0] V_VISIBLE = kbd_vga_pkg::V_VISIBLE,
	parameter logic [9:0] V_FRONT = kbd_vga_pkg::V_FRONT,
	parameter logic [9:0] V_SYNC = kbd_vga_pkg::V_SYNC,
	parameter logic [9:0] V_BACK = kbd_vga_pkg::V_BACK
) (
	input logic clk,
	input logic rst,
	output logic [9:0] h_addr,
	output logic [9:0] v_addr,
	output logic visible,
	output logic hsync,
	output logic vsync
);
	localparam logic [9:0] H_SYNC_START = H_VISIBLE + H_FRONT;
	localparam logic [9:0] H_SYNC_END = H_SYNC_START + H_SYNC;
	localparam logic [9:0] H_TOTAL = H_SYNC_END + H_BACK;
	localparam logic [9:0] V_SYNC_START = V_VISIBLE + V_FRONT;
	localparam logic [9:0] V_SYNC_END = V_SYNC_START + V_SYNC;
	localparam logic [9:0] V_TOTAL = V_SYNC_END + V_BACK;

	logic [9:0] h_cnt;
	logic [9:0] v_cnt;
	logic h_wrap;
	logic v_wrap;

	assign h_wrap = (h_cnt == H_TOTAL - 10'd1);
	assign v_wrap = (v_cnt == V_TOTAL - 10'd1);

	always_ff @(posedge clk) begin
		if (rst) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else begin
			h_cnt <= h_wrap ? 10'd0 : h_cnt + 10'd1;
			if (h_wrap) begin
				v_cnt <= v_wrap ? 10'd0 : v_cnt + 10'd1;
			end
		end
	end

	// Active low pulses
	assign hsync = !((h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END));
	assign vsync = !((v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END));
	assign visible = (h_cnt < H_VISIBLE) && (v_cnt < V_VISIBLE);

	assign h_addr = (h_cnt < H_VISIBLE) ? h_cnt : 10'd0;
	assign v_addr = (v_cnt < V_VISIBLE) ? v_cnt : 10'd0;

	v_addr_on_wrap: assert property (@(posedge clk) disable iff (rst)
		(v_addr != $past(v_addr)) |-> $past(h_wrap));

endmodule

//--- logic/pixel_source.sv
module pixel_source (
	input logic clk,
	input logic rst,
	input logic [9:0] h_addr,
	input logic [9:0] v_addr,
	input logic visible,
	input logic hsync,
	input logic vsync,
	input logic [7:0] last_key,
	input logic key_held,
	output logic vga_hsync,
	output logic vga_vsync,
	output logic blank_n,
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b
);
	logic [7:0] grey;
	logic [7:0] key_r;
	logic [7:0] key_g;
	logic [7:0] key_b;

	assign grey = h_addr[7:0] + v_addr[7:0];

	// 3-3-2 RGB widened by repeating each field
	assign key_r = {last_key[7:5], last_key[7:5], last_key[7:6]};
	assign key_g = {last_key[4:2], last_key[4:2], last_key[4:3]};
	assign key_b = {4{last_key[1:0]}};

	always_ff @(posedge clk) begin
		if (rst) begin
			vga_hsync <= 1'b1;
			vga_vsync <= 1'b1;
			blank_n <= 1'b0;
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
		end else begin
			vga_hsync <= hsync;
			vga_vsync <= vsync;
			blank_n <= visible;
			if (!visible) begin
				vga_r <= '0;
				vga_g <= '0;
				vga_b <= '0;
			end else if (key_held) begin
				vga_r <= key_r;
				vga_g <= key_g;
				vga_b <= key_b;
			end else begin
				vga_r <= grey;
				vga_g <= grey;
				vga_b <= grey;
			end
		end
	end

endmodule

//--- logic/kbd_vga_top.sv
module kbd_vga_top #(
	parameter logic [9:0] H_VISIBLE = kbd_vga_pkg::H_VISIBLE,
	parameter logic [9:0] H_FRONT = kbd_vga_pkg::H_FRONT,
	parameter logic [9:0] H_SYNC = kbd_vga_pkg::H_SYNC,
	parameter logic [9:0] H_BACK = kbd_vga_pkg::H_BACK,
	parameter logic [9:0] V_VISIBLE = kbd_vga_pkg::V_VISIBLE,
	parameter logic [9:0] V_FRONT = kbd_vga_pkg::V_FRONT,
	parameter logic [9:0] V_SYNC = kbd_vga_pkg::V_SYNC,
	parameter logic [9:0] V_BACK = kbd_vga_pkg::V_BACK,
	parameter int FIFO_DEPTH = kbd_vga_pkg::FIFO_DEPTH
) (
	input logic clk,
	input logic rst,
	input logic ps2_clk,
	input logic ps2_data,
	output logic [15:0] ledr,
	output logic VGA_CLK,
	output logic VGA_HSYNC,
	output logic VGA_VSYNC,
	output logic VGA_BLANK_N,
	output logic [7:0] VGA_R,
	output logic [7:0] VGA_G,
	output logic [7:0] VGA_B
);
	logic parity_error;
	logic [7:0] last_key;
	logic key_held;
	logic break_pending;
	logic [7:0] press_count;
	logic [9:0] h_addr;
	logic [9:0] v_addr;
	logic visible;
	logic hsync;
	logic vsync;

	ps2_rx_if rx_bus ();

	// Keyboard path
	ps2_receiver #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) ps2_receiver_i (
		.clk(clk),
		.rst(rst),
		.ps2_clk(ps2_clk),
		.ps2_data(ps2_data),
		.parity_error(parity_error),
		.rx(rx_bus.source)
	);

	key_tracker key_tracker_i (
		.clk(clk),
		.rst(rst),
		.rx(rx_bus.sink),
		.last_key(last_key),
		.key_held(key_held),
		.break_pending(break_pending),
		.press_count(press_count)
	);

	// Video path
	vga_timing #(
		.H_VISIBLE(H_VISIBLE),
		.H_FRONT(H_FRONT),
		.H_SYNC(H_SYNC),
		.H_BACK(H_BACK),
		.V_VISIBLE(V_VISIBLE),
		.V_FRONT(V_FRONT),
		.V_SYNC(V_SYNC),
		.V_BACK(V_BACK)
	) vga_timing_i (
		.clk(clk),
		.rst(rst),
		.h_addr(h_addr),
		.v_addr(v_addr),
		.visible(visible),
		.hsync(hsync),
		.vsync(vsync)
	);

	pixel_source pixel_source_i (
		.clk(clk),
		.rst(rst),
		.h_addr(h_addr),
		.v_addr(v_addr),
		.visible(visible),
		.hsync(hsync),
		.vsync(vsync),
		.last_key(last_key),
		.key_held(key_held),
		.vga_hsync(VGA_HSYNC),
		.vga_vsync(VGA_VSYNC),
		.blank_n(VGA_BLANK_N),
		.vga_r(VGA_R),
		.vga_g(VGA_G),
		.vga_b(VGA_B)
	);

	assign VGA_CLK = clk;

	// Only the low three bits of the press count fit on the LEDs
	assign ledr = {last_key, press_count[2:0], key_held, break_pending,
		rx_bus.overflow, rx_bus.ready, parity_error};

endmodule

//--- testbench/tb_clock.sv
module tb_clock #(
	parameter int PERIOD = 10
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD / 2) clk = ~clk;
		end
	end

endmodule

//--- testbench/kbd_vga_tb.sv
module kbd_vga_tb;

	logic clk;
	logic rst;
	logic ps2_clk;
	logic ps2_data;
	logic [15:0] ledr;
	logic vga_clk;
	logic vga_hsync;
	logic vga_vsync;
	logic vga_blank_n;
	logic [7:0] vga_r;
	logic [7:0] vga_g;
	logic [7:0] vga_b;

	int errors;
	int checks;
	int seed;
	logic timed_out;
	int clk_rise_at;
	int vga_clk_rise_at;

	tb_clock clock_i (
		.clk(clk)
	);

	// Small screen, 22 cycles per line and 11 lines per frame
	kbd_vga_top #(
		.H_VISIBLE(10'd16),
		.H_FRONT(10'd2),
		.H_SYNC(10'd2),
		.H_BACK(10'd2),
		.V_VISIBLE(10'd8),
		.V_FRONT(10'd1),
		.V_SYNC(10'd1),
		.V_BACK(10'd1)
	) kbd_vga_top_i (
		.clk(clk),
		.rst(rst),
		.ps2_clk(ps2_clk),
		.ps2_data(ps2_data),
		.ledr(ledr),
		.VGA_CLK(vga_clk),
		.VGA_HSYNC(vga_hsync),
		.VGA_VSYNC(vga_vsync),
		.VGA_BLANK_N(vga_blank_n),
		.VGA_R(vga_r),
		.VGA_G(vga_g),
		.VGA_B(vga_b)
	);

	// Latest rising edge of the system clock and of the VGA clock output
	always @(posedge clk) begin
		clk_rise_at = int'($time);
	end

	always @(posedge vga_clk) begin
		vga_clk_rise_at = int'($time);
	end

	task automatic check_value(input string test, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("error %s %s: expected %0h, actual %0h", test, what, expected, actual);
		end
	endtask

	task automatic finish_run();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	endtask

	task automatic report_timeout(input string what);
		errors++;
		timed_out = 1'b1;
		$display("timeout while waiting for %s", what);
	endtask

	// Start, data LSB first, odd parity, stop; ps2_clk falls mid-bit
	task automatic send_frame(input logic [7:0] code, input logic bad);
		logic [10:0] bits;
		int i;
		bits = {1'b1, (~^code) ^ bad, code, 1'b0};
		for (i = 0; i < 11; i++) begin
			@(posedge clk);
			ps2_data <= bits[i];
			repeat (8) @(posedge clk);
			ps2_clk <= 1'b0;
			repeat (7) @(posedge clk);
			ps2_clk <= 1'b1;
		end
	endtask

	task automatic wait_idle(input string test);
		int waited;
		int quiet;
		waited = 0;
		quiet = 0;
		while (quiet < 8 && waited < 400) begin
			@(negedge clk);
			waited++;
			if (ledr[1]) begin
				quiet = 0;
			end else begin
				quiet++;
			end
		end
		if (quiet < 8) begin
			report_timeout({"the receive queue to drain in ", test});
		end
	endtask

	task automatic check_video(input string test, input logic held, input logic [23:0] rgb);
		int waited;
		int t;
		int h_low;
		int h_since;
		int v_low;
		int v_since;
		int v_falls;
		int b_run;
		int b_runs;
		logic h_seen;
		logic h_prev;
		logic v_prev;
		logic b_prev;
		logic found;
		logic [7:0] grey;
		waited = 0;
		found = 1'b0;
		@(negedge clk);
		v_prev = vga_vsync;
		while (!found && waited < 1000) begin
			@(negedge clk);
			waited++;
			found = v_prev && !vga_vsync;
			v_prev = vga_vsync;
		end
		if (!found) begin
			report_timeout({"a vertical sync pulse in ", test});
			return;
		end
		h_prev = vga_hsync;
		b_prev = vga_blank_n;
		h_low = 0;
		h_since = 0;
		h_seen = 1'b0;
		v_low = 1;
		v_since = 0;
		v_falls = 0;
		b_run = 0;
		b_runs = 0;
		// Two whole frames counted from the vsync edge
		for (t = 1; t < 484; t++) begin
			@(negedge clk);
			check_value(test, "VGA_CLK rising edge", clk_rise_at, vga_clk_rise_at);
			h_since++;
			v_since++;
			if (!vga_hsync) begin
				h_low++;
			end
			if (h_prev && !vga_hsync) begin
				if (h_seen) begin
					check_value(test, "hsync period", 22, h_since);
				end
				h_seen = 1'b1;
				h_since = 0;
			end
			if (!h_prev && vga_hsync) begin
				check_value(test, "hsync width", 2, h_low);
				h_low = 0;
			end
			if (!vga_vsync) begin
				v_low++;
			end
			if (v_prev && !vga_vsync) begin
				v_falls++;
				check_value(test, "vsync period", 242, v_since);
			end
			if (!v_prev && vga_vsync) begin
				check_value(test, "vsync width", 22, v_low);
				v_low = 0;
			end
			if (vga_blank_n) begin
				b_run++;
				if (held) begin
					check_value(test, "red", rgb[23:16], vga_r);
					check_value(test, "green", rgb[15:8], vga_g);
					check_value(test, "blue", rgb[7:0], vga_b);
				end else begin
					// Ramp is pixel column plus line number
					grey = 8'(b_run - 1 + b_runs % 8);
					check_value(test, "grey red", grey, vga_r);
					check_value(test, "grey green", grey, vga_g);
					check_value(test, "grey blue", grey, vga_b);
				end
			end else begin
				check_value(test, "blanked colour", 0, {vga_r, vga_g, vga_b});
			end
			if (b_prev && !vga_blank_n) begin
				check_value(test, "visible pixels per line", 16, b_run);
				b_run = 0;
				b_runs++;
			end
			h_prev = vga_hsync;
			v_prev = vga_vsync;
			b_prev = vga_blank_n;
		end
		check_value(test, "visible lines in two frames", 16, b_runs);
		check_value(test, "vsync pulses", 1, v_falls);
	endtask

	initial begin
		int fd;
		int got;
		int i;
		int gap;
		string line;
		string name;
		logic pending;
		logic [31:0] gap_on;
		logic [31:0] bad;
		logic [31:0] n;
		logic [31:0] key;
		logic [31:0] count;
		logic [31:0] held;
		logic [31:0] perr;
		logic [31:0] rgb;
		logic [31:0] b [10];
		errors = 0;
		checks = 0;
		seed = 95198;
		timed_out = 1'b0;
		pending = 1'b0;
		rst = 1'b1;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_value("reset", "ledr", 16'h0000, ledr);
		fd = $fopen("testbench/kbd_vga_golden.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open testbench/kbd_vga_golden.txt");
			finish_run();
		end else begin
			while (!$feof(fd) && !timed_out) begin
				got = $fgets(line, fd);
				if (got > 1 && line.getc(0) != "#") begin
					got = $sscanf(line,
						"%s %d %d %d %h %h %h %h %h %h %h %h %h %h %h %d %d %d %h",
						name, gap_on, bad, n, b[0], b[1], b[2], b[3], b[4], b[5],
						b[6], b[7], b[8], b[9], key, count, held, perr, rgb);
					if (got != 19 || n > 10) begin
						errors++;
						$display("golden line could not be read: %s", line);
					end else begin
						for (i = 0; i < n; i++) begin
							send_frame(b[i][7:0], bad[0]);
							// F0 arms a release, the next byte completes it
							if (!bad[0]) begin
								pending = !pending && (b[i][7:0] == 8'hf0);
							end
							if (gap_on != 0) begin
								gap = 20 + (($random(seed) & 32'h7fffffff) % 61);
								repeat (gap) @(posedge clk);
								@(negedge clk);
								check_value(name, "break pending", pending, ledr[3]);
							end
						end
						wait_idle(name);
						if (timed_out) begin
							break;
						end
						check_value(name, "last key", key, ledr[15:8]);
						check_value(name, "press count", count & 32'd7, ledr[7:5]);
						check_value(name, "held", held, ledr[4]);
						check_value(name, "break pending", pending, ledr[3]);
						check_value(name, "overflow", 0, ledr[2]);
						check_value(name, "parity error", perr, ledr[0]);
						check_video(name, held[0], rgb[23:0]);
					end
				end
			end
			$fclose(fd);
			finish_run();
		end
	end

endmodule

//--- filelist.f
logic/kbd_vga_pkg.sv
logic/ps2_rx_if.sv
logic/ps2_receiver.sv
logic/key_tracker.sv
logic/vga_timing.sv
logic/pixel_source.sv
logic/kbd_vga_top.sv
testbench/tb_clock.sv
testbench/kbd_vga_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal
TOP ?= kbd_vga_tb
FILELIST ?= filelist.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf obj_dir

//--- testbench/kbd_vga_golden.txt
# name gap bad n  b0 b1 b2 b3 b4 b5 b6 b7 b8 b9  key count held perr rgb
# gap 1 puts random idle time between frames, bad 1 flips the parity bit of every frame
make_1c     1 0 1  1c 00 00 00 00 00 00 00 00 00  1c 0 1 0 00ff00
release_1c  1 0 2  f0 1c 00 00 00 00 00 00 00 00  1c 1 0 0 000000
make_5a     1 0 1  5a 00 00 00 00 00 00 00 00 00  5a 1 1 0 49dbaa
bad_parity  1 1 1  33 00 00 00 00 00 00 00 00 00  5a 1 1 1 49dbaa
release_5a  1 0 2  f0 5a 00 00 00 00 00 00 00 00  5a 2 0 1 000000
burst       0 0 10 1c f0 1c 32 f0 32 23 f0 23 2b  2b 5 1 1 2449ff
release_2b  1 0 2  f0 2b 00 00 00 00 00 00 00 00  2b 6 0 1 000000
count_wrap  1 0 6  16 f0 16 1e f0 1e 00 00 00 00  1e 8 0 1 000000
make_ff     1 0 1  ff 00 00 00 00 00 00 00 00 00  ff 8 1 1 ffffff
make_e0     1 0 1  e0 00 00 00 00 00 00 00 00 00  e0 8 1 1 ff0000
release_e0  1 0 2  f0 e0 00 00 00 00 00 00 00 00  e0 9 0 1 000000
